// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       := tb_line_engine
RTL_TOP   := line_kcpe_conv2d_engine
FILELIST  := files.f
BUILD_DIR := obj_dir
LOG       := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "Test passed" $(LOG) || (echo "Simulation did not pass"; exit 1)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: files.f
logic/conv_pkg.sv
logic/conf_if.sv
logic/conf_regs.sv
logic/weight_buffer.sv
logic/line_window.sv
logic/kernel_channel_pe.sv
logic/psum_reducer.sv
logic/engine_ctrl.sv
logic/line_kcpe_conv2d_engine.sv
testbench/tb_line_engine.sv

// File: logic/conf_if.sv
`timescale 1ns/100ps
`default_nettype none

interface conf_if
    import conv_pkg::*;
    ();

    logic      enable;
    line_pos_t line_width;
    ksize_t    ksize;
    line_cnt_t line_count;

    // Register block side
    modport master (
        output enable, line_width, ksize, line_count
    );

    // Datapath and control side
    modport slave (
        input enable, line_width, ksize, line_count
    );

endinterface

`default_nettype wire

// File: logic/conf_regs.sv
`timescale 1ns/100ps
`default_nettype none

module conf_regs
    import conv_pkg::*;
    (
    input  wire logic      clk,
    input  wire logic      rst,
    input  wire logic      i_cfg_we,
    input  wire cfg_addr_t i_cfg_addr,
    input  wire cfg_data_t i_cfg_wdata,
    conf_if.master         conf
    );

    logic      enable_q;
    line_pos_t width_q;
    ksize_t    ksize_q;
    line_cnt_t lines_q;

    // Only the low bits of each field are kept
    always_ff @(posedge clk) begin
        if (rst) begin
            enable_q <= 1'b0;
            width_q  <= '0;
            ksize_q  <= '0;
            lines_q  <= '0;
        end else if (i_cfg_we) begin
            case (i_cfg_addr)
                CFG_ADDR_CTRL:  enable_q <= i_cfg_wdata[0];
                CFG_ADDR_WIDTH: width_q  <= i_cfg_wdata[7:0];
                CFG_ADDR_KSIZE: ksize_q  <= i_cfg_wdata[1:0];
                CFG_ADDR_LINES: lines_q  <= i_cfg_wdata[7:0];
                default:        enable_q <= enable_q;
            endcase
        end
    end

    assign conf.enable     = enable_q;
    assign conf.line_width = width_q;
    assign conf.ksize      = ksize_q;
    assign conf.line_count = lines_q;

    // Kernel width must be one to three taps
    a_ksize_range: assert property (@(posedge clk) disable iff (rst)
        (i_cfg_we && i_cfg_addr == CFG_ADDR_KSIZE) |-> (i_cfg_wdata inside {[1:3]}))
        else $error("ksize write out of range: %0d", i_cfg_wdata);

endmodule

`default_nettype wire

// File: logic/conv_pkg.sv
`default_nettype none

package conv_pkg;

    ////////////////////
    // Sizes
    localparam int PIX_W   = 8;
    localparam int NUM_CH  = 3;
    localparam int NUM_KN  = 4;
    localparam int NUM_TAP = 3;

    ////////////////////
    // Data types
    // One channel value or one psum
    typedef logic [PIX_W-1:0] pix_t;
    // Channel c in byte c
    typedef logic [NUM_CH*PIX_W-1:0] pixel_t;
    // Kernel k, channel c in byte 3k+c
    typedef logic [NUM_KN*NUM_CH*PIX_W-1:0] weight_word_t;
    // Kernel k in byte k
    typedef logic [NUM_KN*PIX_W-1:0] psum_vec_t;
    typedef logic [7:0] line_pos_t;
    typedef logic [1:0] ksize_t;
    typedef logic [7:0] line_cnt_t;
    typedef logic [1:0] cfg_addr_t;
    typedef logic [15:0] cfg_data_t;

    ////////////////////
    // Register map
    localparam cfg_addr_t CFG_ADDR_CTRL  = 2'd0;
    localparam cfg_addr_t CFG_ADDR_WIDTH = 2'd1;
    localparam cfg_addr_t CFG_ADDR_KSIZE = 2'd2;
    localparam cfg_addr_t CFG_ADDR_LINES = 2'd3;

endpackage

`default_nettype wire

// File: logic/engine_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module engine_ctrl
    import conv_pkg::*;
    (
    input  wire logic clk,
    input  wire logic rst,
    conf_if.slave     conf,
    input  wire logic i_weights_full,
    input  wire logic i_line_last,
    input  wire logic i_psum_end,
    output logic      o_weight_req,
    output logic      o_data_req,
    output logic      o_done
    );

    typedef enum logic [1:0] {
        S_IDLE,
        S_LOAD,
        S_STREAM,
        S_DONE
    } state_t;

    state_t    state;
    line_cnt_t line_cnt;
    logic      final_last;

    always_ff @(posedge clk) begin
        if (rst || !conf.enable) begin
            state    <= S_IDLE;
            line_cnt <= '0;
        end else begin
            case (state)
                S_IDLE:   state <= S_LOAD;
                S_LOAD:   if (i_weights_full) state <= S_STREAM;
                S_STREAM: if (i_psum_end && line_cnt == conf.line_count) state <= S_DONE;
                default:  state <= S_DONE;
            endcase
            if (i_line_last) begin
                line_cnt <= line_cnt + line_cnt_t'(1);
            end
        end
    end

    // Last pixel of line L was taken on the previous edge
    assign final_last = i_line_last && (line_cnt + line_cnt_t'(1) == conf.line_count);

    assign o_weight_req = (state == S_LOAD) && !i_weights_full;
    assign o_data_req   = conf.enable && i_weights_full && (line_cnt < conf.line_count)
                          && (state != S_DONE) && !final_last;
    assign o_done       = (state == S_DONE);

    // A fresh enable must reload weights before any pixel is requested
    a_no_data_in_idle: assert property (@(posedge clk) disable iff (rst)
        (state == S_IDLE) |-> !o_data_req)
        else $error("data request before weight load");

endmodule

`default_nettype wire

// File: logic/kernel_channel_pe.sv
`timescale 1ns/100ps
`default_nettype none

module kernel_channel_pe
    import conv_pkg::*;
    (
    input  wire logic         clk,
    input  wire logic         rst,
    input  wire pixel_t       i_pixel,
    input  wire weight_word_t i_weight,
    output psum_vec_t         o_psum
    );

    psum_vec_t psum_next;

    // Three channel products per kernel, kept to 8 bits
    always_comb begin
        pix_t acc;
        for (int k = 0; k < NUM_KN; k++) begin
            acc = '0;
            for (int c = 0; c < NUM_CH; c++) begin
                acc = acc + i_pixel[c*PIX_W +: PIX_W]
                          * i_weight[(k*NUM_CH + c)*PIX_W +: PIX_W];
            end
            psum_next[k*PIX_W +: PIX_W] = acc;
        end
    end

    // Free running, validity travels alongside in the reducer
    always_ff @(posedge clk) begin
        if (rst) begin
            o_psum <= '0;
        end else begin
            o_psum <= psum_next;
        end
    end

endmodule

`default_nettype wire

// File: logic/line_kcpe_conv2d_engine.sv
`timescale 1ns/100ps
`default_nettype none

module line_kcpe_conv2d_engine
    import conv_pkg::*;
    (
    input  wire logic         clk,
    input  wire logic         rst,
    input  wire logic         i_cfg_we,
    input  wire cfg_addr_t    i_cfg_addr,
    input  wire cfg_data_t    i_cfg_wdata,
    input  wire weight_word_t i_weight,
    input  wire logic         i_weight_val,
    output logic              o_weight_req,
    input  wire pixel_t       i_data,
    input  wire logic         i_data_val,
    output logic              o_data_req,
    output pix_t              o_psum_kn0,
    output pix_t              o_psum_kn1,
    output pix_t              o_psum_kn2,
    output pix_t              o_psum_kn3,
    output logic              o_psum_val,
    output logic              o_psum_end,
    output logic              o_done
    );

    weight_word_t tap_weights [NUM_TAP];
    logic         weights_full;
    pixel_t       window [NUM_TAP];
    logic         win_val;
    line_pos_t    pos;
    logic         line_last;
    psum_vec_t    tap_psum [NUM_TAP];
    psum_vec_t    psum;

    conf_if conf ();

    conf_regs u_conf_regs (
        .clk, .rst, .i_cfg_we, .i_cfg_addr, .i_cfg_wdata, .conf(conf)
    );

    weight_buffer u_weight_buffer (
        .clk, .rst, .conf(conf), .i_weight_req(o_weight_req), .i_weight, .i_weight_val,
        .o_tap_weights(tap_weights), .o_weights_full(weights_full)
    );

    line_window u_line_window (
        .clk, .rst, .conf(conf), .i_data, .i_data_val, .i_data_req(o_data_req),
        .o_window(window), .o_win_val(win_val), .o_pos(pos), .o_line_last(line_last)
    );

    ////////////////////
    // One PE per tap
    for (genvar t = 0; t < NUM_TAP; t++) begin : g_pe
        kernel_channel_pe u_pe (
            .clk, .rst, .i_pixel(window[t]), .i_weight(tap_weights[t]), .o_psum(tap_psum[t])
        );
    end

    psum_reducer u_psum_reducer (
        .clk, .rst, .conf(conf), .i_tap_psum(tap_psum), .i_win_val(win_val), .i_pos(pos),
        .i_line_last(line_last), .o_psum(psum), .o_psum_val, .o_psum_end
    );

    engine_ctrl u_engine_ctrl (
        .clk, .rst, .conf(conf), .i_weights_full(weights_full), .i_line_last(line_last),
        .i_psum_end(o_psum_end), .o_weight_req, .o_data_req, .o_done
    );

    // Kernel k in byte k
    assign o_psum_kn0 = psum[0*PIX_W +: PIX_W];
    assign o_psum_kn1 = psum[1*PIX_W +: PIX_W];
    assign o_psum_kn2 = psum[2*PIX_W +: PIX_W];
    assign o_psum_kn3 = psum[3*PIX_W +: PIX_W];

endmodule

`default_nettype wire

// File: logic/line_window.sv
`timescale 1ns/100ps
`default_nettype none

module line_window
    import conv_pkg::*;
    (
    input  wire logic   clk,
    input  wire logic   rst,
    conf_if.slave       conf,
    input  wire pixel_t i_data,
    input  wire logic   i_data_val,
    input  wire logic   i_data_req,
    output pixel_t      o_window [NUM_TAP],
    output logic        o_win_val,
    output line_pos_t   o_pos,
    output logic        o_line_last
    );

    line_pos_t col;
    logic      accept;
    logic      col_last;

    // Only place where the request gates the input
    assign accept   = i_data_val && i_data_req;
    assign col_last = (col == conf.line_width - line_pos_t'(1));

    // Position of the next pixel within its line
    always_ff @(posedge clk) begin
        if (rst || !conf.enable) begin
            col <= '0;
        end else if (accept) begin
            col <= col_last ? '0 : col + line_pos_t'(1);
        end
    end

    // Slot t holds pixel p-t, not cleared between lines
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int t = 0; t < NUM_TAP; t++) begin
                o_window[t] <= '0;
            end
            o_pos <= '0;
        end else if (accept) begin
            o_window[0] <= i_data;
            for (int t = 1; t < NUM_TAP; t++) begin
                o_window[t] <= o_window[t-1];
            end
            o_pos <= col;
        end
    end

    // Single cycle strobes
    always_ff @(posedge clk) begin
        if (rst) begin
            o_win_val   <= 1'b0;
            o_line_last <= 1'b0;
        end else begin
            o_win_val   <= accept;
            o_line_last <= accept && col_last;
        end
    end

endmodule

`default_nettype wire

// File: logic/psum_reducer.sv
`timescale 1ns/100ps
`default_nettype none

module psum_reducer
    import conv_pkg::*;
    (
    input  wire logic      clk,
    input  wire logic      rst,
    conf_if.slave          conf,
    input  wire psum_vec_t i_tap_psum [NUM_TAP],
    input  wire logic      i_win_val,
    input  wire line_pos_t i_pos,
    input  wire logic      i_line_last,
    output psum_vec_t      o_psum,
    output logic           o_psum_val,
    output logic           o_psum_end
    );

    logic      val_d;
    logic      last_d;
    line_pos_t pos_d;
    logic      pos_ok;
    psum_vec_t sum_next;

    // Match the PE register stage
    always_ff @(posedge clk) begin
        if (rst) begin
            val_d  <= 1'b0;
            last_d <= 1'b0;
            pos_d  <= '0;
        end else begin
            val_d  <= i_win_val;
            last_d <= i_line_last;
            pos_d  <= i_pos;
        end
    end

    // Taps at or above ksize are dropped
    always_comb begin
        pix_t acc;
        for (int k = 0; k < NUM_KN; k++) begin
            acc = '0;
            for (int t = 0; t < NUM_TAP; t++) begin
                if (t < conf.ksize) begin
                    acc = acc + i_tap_psum[t][k*PIX_W +: PIX_W];
                end
            end
            sum_next[k*PIX_W +: PIX_W] = acc;
        end
    end

    // Window is full once p >= K-1
    assign pos_ok = ({1'b0, pos_d} + 9'd1) >= {7'd0, conf.ksize};

    always_ff @(posedge clk) begin
        if (rst) begin
            o_psum     <= '0;
            o_psum_val <= 1'b0;
            o_psum_end <= 1'b0;
        end else begin
            o_psum     <= sum_next;
            o_psum_val <= val_d && pos_ok;
            o_psum_end <= val_d && pos_ok && last_d;
        end
    end

    // Line end from the window only comes with an accepted pixel
    a_end_has_val: assert property (@(posedge clk) disable iff (rst)
        i_line_last |-> i_win_val)
        else $error("line end without a valid window");

endmodule

`default_nettype wire

// File: logic/weight_buffer.sv
`timescale 1ns/100ps
`default_nettype none

module weight_buffer
    import conv_pkg::*;
    (
    input  wire logic         clk,
    input  wire logic         rst,
    conf_if.slave             conf,
    input  wire logic         i_weight_req,
    input  wire weight_word_t i_weight,
    input  wire logic         i_weight_val,
    output weight_word_t      o_tap_weights [NUM_TAP],
    output logic              o_weights_full
    );

    logic [1:0] fill_cnt;
    logic       take;

    assign take = i_weight_val && i_weight_req;

    // Words arrive tap 0 first
    always_ff @(posedge clk) begin
        if (rst || !conf.enable) begin
            fill_cnt       <= '0;
            o_weights_full <= 1'b0;
            for (int t = 0; t < NUM_TAP; t++) begin
                o_tap_weights[t] <= '0;
            end
        end else if (take) begin
            o_tap_weights[fill_cnt] <= i_weight;
            fill_cnt                <= fill_cnt + 2'd1;
            if (fill_cnt == 2'(NUM_TAP - 1)) begin
                o_weights_full <= 1'b1;
            end
        end
    end

    ////////////////////
    // Checks
    // Controller must drop the request once all taps are loaded
    a_no_overfill: assert property (@(posedge clk) disable iff (rst)
        take |-> !o_weights_full)
        else $error("weight word accepted while buffer full");

endmodule

`default_nettype wire

// File: testbench/tb_line_engine.sv
`timescale 1ns/100ps
`default_nettype none

module tb_line_engine
    import conv_pkg::*;
    ();

    // Three runs with K = 3, then K = 1 and K = 2 after a reload
    localparam int RUN0_W = 12;
    localparam int RUN0_K = 3;
    localparam int RUN0_L = 3;
    localparam int RUN1_W = 10;
    localparam int RUN1_K = 1;
    localparam int RUN1_L = 2;
    localparam int RUN2_W = 9;
    localparam int RUN2_K = 2;
    localparam int RUN2_L = 3;
    localparam int TOTAL_PIX   = RUN0_W * RUN0_L + RUN1_W * RUN1_L + RUN2_W * RUN2_L;
    localparam int TIMEOUT_CYC = 20 * TOTAL_PIX + 1000;

    typedef struct packed {
        psum_vec_t   psum;
        logic        last;
        logic [31:0] cyc;
    } expect_t;

    logic         clk;
    logic         rst;
    logic         i_cfg_we;
    cfg_addr_t    i_cfg_addr;
    cfg_data_t    i_cfg_wdata;
    weight_word_t i_weight;
    logic         i_weight_val;
    logic         o_weight_req;
    pixel_t       i_data;
    logic         i_data_val;
    logic         o_data_req;
    pix_t         o_psum_kn0;
    pix_t         o_psum_kn1;
    pix_t         o_psum_kn2;
    pix_t         o_psum_kn3;
    logic         o_psum_val;
    logic         o_psum_end;
    logic         o_done;

    logic [31:0]  lfsr;
    logic [31:0]  cyc;
    weight_word_t wts [NUM_TAP];
    pixel_t       hist [NUM_TAP];
    int           cur_w;
    int           cur_k;
    int           cur_l;
    int           model_pos;
    int           out_count;
    int           lines_seen;
    expect_t      exp_q [$];

    line_kcpe_conv2d_engine i_dut (
        .clk, .rst, .i_cfg_we, .i_cfg_addr, .i_cfg_wdata, .i_weight, .i_weight_val,
        .o_weight_req, .i_data, .i_data_val, .o_data_req, .o_psum_kn0, .o_psum_kn1,
        .o_psum_kn2, .o_psum_kn3, .o_psum_val, .o_psum_end, .o_done
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Cycle stamp for output arrival
    always @(posedge clk) begin
        if (rst) begin
            cyc <= '0;
        end else begin
            cyc <= cyc + 32'd1;
        end
    end

    ////////////////////
    // Helpers
    // Fibonacci LFSR with taps 32 22 2 1 and one step per bit
    function automatic logic [95:0] rand_bits(input int n);
        logic [95:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            r    = {r[94:0], fb};
        end
        return r;
    endfunction

    // Sum over taps below K and all channels modulo 256
    function automatic psum_vec_t model_psum();
        psum_vec_t res;
        int        sum;
        res = '0;
        for (int k = 0; k < NUM_KN; k++) begin
            sum = 0;
            for (int t = 0; t < cur_k; t++) begin
                for (int c = 0; c < NUM_CH; c++) begin
                    sum += int'(wts[t][(3*k + c)*8 +: 8]) * int'(hist[t][c*8 +: 8]);
                end
            end
            res[k*8 +: 8] = 8'(sum % 256);
        end
        return res;
    endfunction

    task automatic check_equal(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("Mismatch at %0t ns: %s, got %0h, expected %0h",
                     $time, what, actual, expected);
            $display("Test failed");
            $fatal(1, "value check");
        end
    endtask

    task automatic write_reg(input cfg_addr_t addr, input cfg_data_t data);
        @(negedge clk);
        i_cfg_we    = 1'b1;
        i_cfg_addr  = addr;
        i_cfg_wdata = data;
        @(negedge clk);
        i_cfg_we = 1'b0;
    endtask

    // Called on the drive edge of a pixel that the DUT takes
    task automatic accept_pixel(input pixel_t pix);
        expect_t e;
        for (int t = NUM_TAP - 1; t > 0; t--) begin
            hist[t] = hist[t-1];
        end
        hist[0] = pix;
        if (model_pos >= cur_k - 1) begin
            e.psum = model_psum();
            e.last = (model_pos == cur_w - 1);
            e.cyc  = cyc + 32'd3;
            exp_q.push_back(e);
        end
        model_pos = (model_pos == cur_w - 1) ? 0 : model_pos + 1;
    endtask

    task automatic load_weights();
        logic [95:0] rnd;
        int          n;
        n = 0;
        while (n < NUM_TAP) begin
            @(negedge clk);
            check_equal(o_weight_req, 1, "weight request during load");
            rnd          = rand_bits(96);
            i_weight     = rnd;
            rnd          = rand_bits(2);
            i_weight_val = (rnd != 0);
            if (i_weight_val) begin
                wts[n] = i_weight;
                n++;
            end
        end
        // Keep offering a word that the full buffer must not take
        @(negedge clk);
        rnd          = rand_bits(96);
        i_weight     = rnd;
        i_weight_val = 1'b1;
        check_equal(o_weight_req, 0, "weight request after three words");
        check_equal(o_data_req, 1, "data request after weight load");
    endtask

    task automatic stream_pixels();
        logic [95:0] rnd;
        int          sent;
        sent = 0;
        while (sent < cur_w * cur_l) begin
            @(negedge clk);
            check_equal(o_data_req, 1, "data request while streaming");
            rnd        = rand_bits(24);
            i_data     = rnd[23:0];
            rnd        = rand_bits(2);
            i_data_val = (rnd != 0);
            if (i_data_val) begin
                accept_pixel(i_data);
                sent++;
            end
        end
        // Keep offering pixels that must not be taken
        @(negedge clk);
        i_data_val = 1'b1;
        check_equal(o_data_req, 0, "data request after last line");
        while (!o_done) begin
            @(negedge clk);
        end
        check_equal(exp_q.size(), 0, "outputs still pending at done");
        check_equal(lines_seen, cur_l, "line ends seen");
        repeat (8) @(negedge clk);
        check_equal(o_done, 1, "done held");
        check_equal(o_data_req, 0, "data request while done");
        i_data_val   = 1'b0;
        i_weight_val = 1'b0;
    endtask

    task automatic run_config(input int w, input int k, input int l);
        cur_w      = w;
        cur_k      = k;
        cur_l      = l;
        model_pos  = 0;
        out_count  = 0;
        lines_seen = 0;
        write_reg(CFG_ADDR_WIDTH, cfg_data_t'(w));
        write_reg(CFG_ADDR_KSIZE, cfg_data_t'(k));
        write_reg(CFG_ADDR_LINES, cfg_data_t'(l));
        write_reg(CFG_ADDR_CTRL, 16'd1);
        check_equal(o_weight_req, 0, "weight request on enable edge");
        @(negedge clk);
        check_equal(o_weight_req, 1, "weight request after enable");
        check_equal(o_data_req, 0, "data request before weights");
        load_weights();
        stream_pixels();
    endtask

    task automatic disable_engine();
        write_reg(CFG_ADDR_CTRL, 16'd0);
        @(negedge clk);
        check_equal(o_done, 0, "done after disable");
        check_equal(o_weight_req, 0, "weight request after disable");
        check_equal(o_data_req, 0, "data request after disable");
    endtask

    ////////////////////
    // Output checker
    always @(negedge clk) begin : output_monitor
        logic    want_val;
        expect_t e;
        if (!rst) begin
            want_val = (exp_q.size() != 0);
            if (want_val) begin
                e        = exp_q[0];
                want_val = (e.cyc == cyc);
            end
            check_equal(o_psum_val, want_val, "psum valid strobe");
            if (want_val) begin
                e = exp_q.pop_front();
                check_equal(o_psum_kn0, e.psum[7:0], "kernel 0 psum");
                check_equal(o_psum_kn1, e.psum[15:8], "kernel 1 psum");
                check_equal(o_psum_kn2, e.psum[23:16], "kernel 2 psum");
                check_equal(o_psum_kn3, e.psum[31:24], "kernel 3 psum");
                check_equal(o_psum_end, e.last, "line end strobe");
                out_count++;
                if (o_psum_end) begin
                    check_equal(out_count, cur_w - cur_k + 1, "outputs per line");
                    out_count = 0;
                    lines_seen++;
                end
            end else begin
                check_equal(o_psum_end, 0, "line end without output");
            end
        end
    end

    initial begin
        repeat (TIMEOUT_CYC) @(posedge clk);
        $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYC);
        $display("Test failed");
        $fatal(1, "watchdog");
    end

    initial begin
        lfsr         = 32'h5249;
        rst          = 1'b1;
        i_cfg_we     = 1'b0;
        i_cfg_addr   = '0;
        i_cfg_wdata  = '0;
        i_weight     = '0;
        i_weight_val = 1'b0;
        i_data       = '0;
        i_data_val   = 1'b0;
        for (int t = 0; t < NUM_TAP; t++) begin
            hist[t] = '0;
            wts[t]  = '0;
        end
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        check_equal(o_weight_req, 0, "weight request after reset");
        check_equal(o_data_req, 0, "data request after reset");
        check_equal(o_psum_val, 0, "psum valid after reset");
        check_equal(o_done, 0, "done after reset");

        run_config(RUN0_W, RUN0_K, RUN0_L);
        disable_engine();
        run_config(RUN1_W, RUN1_K, RUN1_L);
        disable_engine();
        run_config(RUN2_W, RUN2_K, RUN2_L);

        $display("Test passed");
        $finish;
    end

endmodule

`default_nettype wire
